// ==== Makefile ====
# Verilator build and run for the symbol FIR testbench

VERILATOR ?= verilator
TOP       ?= symbolFirTb
FILELIST  ?= src.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert

BINARY = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST LOG OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(BINARY) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "NO ERRORS" $(LOG); then \
		echo "test did not complete, see $(LOG)"; \
		exit 1; \
	fi
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== adderTree.sv ====
module adderTree
	import firPkg::*;
(
	input  logic        sys_clk,
	input  logic        reset,
	input  logic        sampleEn,
	input  uniqueTaps_t products,
	output sample_t     treeSum
);

	// each level halves the node count, 8 to 4 to 2 to 1
	for (genvar l = 0; l < TREE_LEVELS; l++) begin : treeLevel
		localparam int NODES = UNIQUE_TAPS >> (l + 1);

		sample_t operand [2 * NODES];
		sample_t node [NODES];

		for (genvar i = 0; i < 2 * NODES; i++) begin : feed
			if (l == 0) begin : fromProducts
				assign operand[i] = products.taps[i];
			end else begin : fromLevel
				assign operand[i] = treeLevel[l - 1].node[i];
			end
		end

		// neighbouring operands pair up into one registered node
		always_ff @(posedge sys_clk) begin
			if (reset) begin
				for (int i = 0; i < NODES; i++) begin
					node[i] <= '0;
				end
			end else if (sampleEn) begin
				for (int i = 0; i < NODES; i++) begin
					node[i] <= operand[2 * i] + operand[2 * i + 1];
				end
			end
		end
	end

	// root of the tree
	assign treeSum = treeLevel[TREE_LEVELS - 1].node[0];

	// every level clears together, so the root is zero right after reset
	assert property (
		@(posedge sys_clk)
		reset |=> (treeSum == '0)
	) else $error("treeSum not cleared by reset");

endmodule

// ==== firPkg.sv ====
package firPkg;

	// every sample, pre-sum, product and tree node shares this width
	localparam int SAMPLE_WIDTH = 18;

	// 15 taps fold into 7 mirrored pairs and one centre tap
	localparam int TAP_COUNT = 15;
	localparam int PAIR_COUNT = (TAP_COUNT - 1) / 2;
	localparam int UNIQUE_TAPS = PAIR_COUNT + 1;

	// depth of the binary tree over the unique taps
	localparam int TREE_LEVELS = $clog2(UNIQUE_TAPS);

	// one quarter of full scale in 2s16
	localparam int QUARTER_STEP = 16384;

	// pair sums land on even quarters, the centre on odd quarters
	localparam int PAIR_LEVEL_COUNT = 7;
	localparam int CENTRE_LEVEL_COUNT = 4;

	// half-width of the open acceptance window around each level
	localparam int MATCH_TOLERANCE = 10;

	typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

	// one word per unique tap, index PAIR_COUNT is the centre
	typedef struct packed {
		sample_t [UNIQUE_TAPS-1:0] taps;
	} uniqueTaps_t;

	// level sets in quarters of full scale
	localparam int PAIR_LEVELS [PAIR_LEVEL_COUNT] = '{-6, -4, -2, 0, 2, 4, 6};
	localparam int CENTRE_LEVELS [CENTRE_LEVEL_COUNT] = '{-3, -1, 1, 3};

	// 0s18 coefficients, outermost pair first and centre tap last
	localparam sample_t COEFFICIENTS [UNIQUE_TAPS] = '{
		18'sd3924,
		18'sd4047,
		18'sd1459,
		-18'sd2677,
		-18'sd5917,
		-18'sd5847,
		-18'sd1639,
		18'sd5023
	};

	// level in quarters for one entry of the pair or centre set
	function automatic int levelQuarters(input bit centre, input int index);
		if (centre) begin
			return CENTRE_LEVELS[index];
		end
		return PAIR_LEVELS[index];
	endfunction

	// 2s16 value that sits at the middle of a level window
	function automatic int levelValue(input int quarters);
		return quarters * QUARTER_STEP;
	endfunction

	// coefficient times level, the divide by four rounds toward minus infinity
	function automatic sample_t levelProduct(input sample_t coef, input int quarters);
		int full;
		full = int'(coef) * quarters;
		return sample_t'(full >>> 2);
	endfunction

endpackage

// ==== levelProductLookup.sv ====
module levelProductLookup
	import firPkg::*;
(
	input  logic        sys_clk,
	input  logic        reset,
	input  logic        sampleEn,
	input  uniqueTaps_t preSums,
	output uniqueTaps_t products
);

	// product picked for each unique tap before the register
	sample_t selected [UNIQUE_TAPS];

	for (genvar k = 0; k < UNIQUE_TAPS; k++) begin : field
		// the last field is the centre tap with its own level set
		localparam bit IS_CENTRE = (k == PAIR_COUNT);
		localparam int LEVELS = IS_CENTRE ? CENTRE_LEVEL_COUNT : PAIR_LEVEL_COUNT;

		logic [LEVELS-1:0] hit;
		sample_t entry [LEVELS];
		sample_t match;
		int fieldValue;

		assign fieldValue = int'(preSums.taps[k]);

		for (genvar j = 0; j < LEVELS; j++) begin : window
			localparam int QUARTERS = levelQuarters(IS_CENTRE, j);
			localparam int MIDDLE = levelValue(QUARTERS);

			// precomputed coefficient times level, no multiplier in hardware
			assign entry[j] = levelProduct(COEFFICIENTS[k], QUARTERS);

			// strictly inside the window on both sides
			assign hit[j] = (fieldValue > MIDDLE - MATCH_TOLERANCE) &&
				(fieldValue < MIDDLE + MATCH_TOLERANCE);
		end

		// off-grid values match nothing and give zero
		always_comb begin
			match = '0;
			for (int j = 0; j < LEVELS; j++) begin
				if (hit[j]) begin
					match = entry[j];
				end
			end
		end

		assign selected[k] = match;

		// windows are far apart, so a second hit means a broken level table
		assert property (
			@(posedge sys_clk) disable iff (reset)
			$onehot0(hit)
		) else $error("field %0d matched more than one level window", k);
	end

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			products <= '0;
		end else if (sampleEn) begin
			for (int k = 0; k < UNIQUE_TAPS; k++) begin
				products.taps[k] <= selected[k];
			end
		end
	end

endmodule

// ==== src.f ====
firPkg.sv
symmetricTapLine.sv
levelProductLookup.sv
adderTree.sv
symbolFir.sv
symbolFirTb.sv

// ==== symbolFir.sv ====
module symbolFir
	import firPkg::*;
(
	input  logic    sys_clk,
	input  logic    reset,
	input  logic    sampleEn,
	input  sample_t sampleIn,
	output sample_t filterOut
);

	uniqueTaps_t preSums;
	uniqueTaps_t products;
	sample_t treeSum;

	// delay line and mirrored pre-add, two enabled cycles
	symmetricTapLine i_symmetricTapLine (
		.sys_clk  (sys_clk),
		.reset    (reset),
		.sampleEn (sampleEn),
		.sampleIn (sampleIn),
		.preSums  (preSums)
	);

	// level match and product select, one enabled cycle
	levelProductLookup i_levelProductLookup (
		.sys_clk  (sys_clk),
		.reset    (reset),
		.sampleEn (sampleEn),
		.preSums  (preSums),
		.products (products)
	);

	// three registered levels
	adderTree i_adderTree (
		.sys_clk  (sys_clk),
		.reset    (reset),
		.sampleEn (sampleEn),
		.products (products),
		.treeSum  (treeSum)
	);

	// output register, seventh enabled stage
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			filterOut <= '0;
		end else if (sampleEn) begin
			filterOut <= treeSum;
		end
	end

endmodule

// ==== symbolFirTb.sv ====
module symbolFirTb
	import firPkg::*;
();

	localparam int CLOCK_PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int RESET_CYCLES = 8;

	// enabled edges from sampleIn to filterOut
	localparam int PIPE_DEPTH = 7;

	// roughly three times the length of all stimulus phases
	localparam int TIMEOUT_CYCLES = 2000;

	// off-grid samples sit this far above a level in 2s16
	localparam int OFF_GRID_OFFSET = 40;

	localparam int RANDOM_SYMBOLS = 300;
	localparam int HOLD_SYMBOLS = 120;
	localparam int OFF_GRID_SYMBOLS = 80;

	logic sys_clk = 1'b0;
	logic reset;
	logic sampleEn;
	sample_t sampleIn;
	sample_t filterOut;

	// level behind the sample on sampleIn
	int driveQuarters;
	bit driveOnGrid;

	// model history in quarters, index 0 newest
	int histLevel [TAP_COUNT];
	bit histValid [TAP_COUNT];
	int expPipe [PIPE_DEPTH];
	sample_t expectedOut;
	sample_t lastOut;

	int seed;
	int cycleCount = 0;

	symbolFir i_symbolFir (
		.sys_clk   (sys_clk),
		.reset     (reset),
		.sampleEn  (sampleEn),
		.sampleIn  (sampleIn),
		.filterOut (filterOut)
	);

	always #(CLOCK_PERIOD / 2) sys_clk = ~sys_clk;

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	// 1s17 input word for a level, optionally pushed off the grid
	function automatic sample_t sampleFor(input int quarters, input bit onGrid);
		int halved;
		halved = quarters * QUARTER_STEP;
		if (!onGrid) begin
			halved = halved + OFF_GRID_OFFSET;
		end
		return sample_t'(halved * 2);
	endfunction

	function automatic int randomSymbol();
		int pick;
		pick = $random(seed) & 3;
		case (pick)
			0: return -3;
			1: return -1;
			2: return 1;
			default: return 3;
		endcase
	endfunction

	// c times n quarters, divided by four toward minus infinity
	function automatic int quarterProduct(input int coef, input int quarters);
		int full;
		full = coef * quarters;
		return full >>> 2;
	endfunction

	// pair sums only match the even levels from -6 to +6
	function automatic bit isPairLevel(input int quarters);
		return (quarters % 2 == 0) && (quarters >= -6) && (quarters <= 6);
	endfunction

	// centre matches the odd levels from -3 to +3
	function automatic bit isCentreLevel(input int quarters);
		return (quarters % 2 != 0) && (quarters >= -3) && (quarters <= 3);
	endfunction

	function automatic int modelSum();
		int total;
		int pairLevel;
		int far;
		total = 0;
		for (int k = 0; k < PAIR_COUNT; k++) begin
			far = TAP_COUNT - 1 - k;
			pairLevel = histLevel[k] + histLevel[far];
			if (histValid[k] && histValid[far] && isPairLevel(pairLevel)) begin
				total += quarterProduct(int'(COEFFICIENTS[k]), pairLevel);
			end
		end
		if (histValid[PAIR_COUNT] && isCentreLevel(histLevel[PAIR_COUNT])) begin
			total += quarterProduct(int'(COEFFICIENTS[PAIR_COUNT]), histLevel[PAIR_COUNT]);
		end
		return total;
	endfunction

	// reference history and expected-value pipe, enabled edges only
	always @(posedge sys_clk) begin
		if (reset) begin
			for (int i = 0; i < TAP_COUNT; i++) begin
				histLevel[i] = 0;
				histValid[i] = 1'b1;
			end
			for (int i = 0; i < PIPE_DEPTH; i++) begin
				expPipe[i] = 0;
			end
		end else if (sampleEn) begin
			for (int i = TAP_COUNT - 1; i > 0; i--) begin
				histLevel[i] = histLevel[i - 1];
				histValid[i] = histValid[i - 1];
			end
			histLevel[0] = driveQuarters;
			histValid[0] = driveOnGrid;
			for (int i = PIPE_DEPTH - 1; i > 0; i--) begin
				expPipe[i] = expPipe[i - 1];
			end
			expPipe[0] = modelSum();
		end
	end

	assign expectedOut = sample_t'(expPipe[PIPE_DEPTH - 1]);

	always @(posedge sys_clk) begin
		lastOut <= filterOut;
	end

	always @(posedge sys_clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			failRun("run timed out before the stimulus finished");
		end
	end

	assert property (
		@(posedge sys_clk) disable iff (reset)
		filterOut == expectedOut
	) else failRun($sformatf("FAILED filterOut: got %h, expected %h",
		$sampled(filterOut), $sampled(expectedOut)));

	assert property (
		@(posedge sys_clk) disable iff (reset)
		!sampleEn |=> $stable(filterOut)
	) else failRun($sformatf("FAILED filterOut during hold: got %h, expected %h",
		$sampled(filterOut), $sampled(lastOut)));

	assert property (
		@(posedge sys_clk)
		reset |=> (filterOut == '0)
	) else failRun($sformatf("FAILED filterOut after reset: got %h, expected %h",
		$sampled(filterOut), sample_t'(0)));

	task automatic driveCycle(input int quarters, input bit onGrid, input bit enable);
		@(posedge sys_clk);
		#DRIVE_DELAY;
		sampleIn = sampleFor(quarters, onGrid);
		driveQuarters = quarters;
		driveOnGrid = onGrid;
		sampleEn = enable;
	endtask

	task automatic pulseReset(input int cycles);
		@(posedge sys_clk);
		#DRIVE_DELAY;
		reset = 1'b1;
		repeat (cycles) @(posedge sys_clk);
		#DRIVE_DELAY;
		reset = 1'b0;
	endtask

	initial begin
		int stretch;
		seed = 32'ha3c1_af47;
		reset = 1'b1;
		sampleEn = 1'b0;
		sampleIn = '0;
		driveQuarters = 0;
		driveOnGrid = 1'b1;
		repeat (RESET_CYCLES) @(posedge sys_clk);
		#DRIVE_DELAY;
		reset = 1'b0;

		// idle zeros after reset
		repeat (20) driveCycle(0, 1'b1, 1'b1);

		// impulse, then zeros until it has left the line
		driveCycle(3, 1'b1, 1'b1);
		repeat (TAP_COUNT + PIPE_DEPTH) driveCycle(0, 1'b1, 1'b1);

		repeat (RANDOM_SYMBOLS) driveCycle(randomSymbol(), 1'b1, 1'b1);

		// held stretches, input keeps moving while held
		repeat (HOLD_SYMBOLS) begin
			if (($random(seed) & 3) == 0) begin
				stretch = 1 + ($random(seed) & 3);
				repeat (stretch) driveCycle(randomSymbol(), 1'b1, 1'b0);
			end
			driveCycle(randomSymbol(), 1'b1, 1'b1);
		end

		// off-grid samples mixed in, then a full line of them
		repeat (OFF_GRID_SYMBOLS) begin
			driveCycle(randomSymbol(), ($random(seed) & 3) != 0, 1'b1);
		end
		repeat (TAP_COUNT) driveCycle(randomSymbol(), 1'b0, 1'b1);

		// reset in the middle of live traffic
		repeat (20) driveCycle(randomSymbol(), 1'b1, 1'b1);
		pulseReset(2);
		repeat (40) driveCycle(randomSymbol(), 1'b1, 1'b1);

		repeat (TAP_COUNT + PIPE_DEPTH) driveCycle(0, 1'b1, 1'b1);
		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== symmetricTapLine.sv ====
module symmetricTapLine
	import firPkg::*;
(
	input  logic        sys_clk,
	input  logic        reset,
	input  logic        sampleEn,
	input  sample_t     sampleIn,
	output uniqueTaps_t preSums
);

	// 1s17 input seen as 2s16, the arithmetic shift keeps the sign
	sample_t scaledIn;

	// index 0 holds the newest sample
	sample_t delayLine [TAP_COUNT];

	assign scaledIn = sampleIn >>> 1;

	// delay line entry and shift
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			for (int i = 0; i < TAP_COUNT; i++) begin
				delayLine[i] <= '0;
			end
		end else if (sampleEn) begin
			delayLine[0] <= scaledIn;
			for (int i = 1; i < TAP_COUNT; i++) begin
				delayLine[i] <= delayLine[i - 1];
			end
		end
	end

	// fold the mirrored taps
	// two halved inputs always fit in the 2s16 range
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			preSums <= '0;
		end else if (sampleEn) begin
			for (int k = 0; k < PAIR_COUNT; k++) begin
				preSums.taps[k] <= delayLine[k] + delayLine[TAP_COUNT - 1 - k];
			end
			// centre tap has no mirror
			preSums.taps[PAIR_COUNT] <= delayLine[PAIR_COUNT];
		end
	end

	// a held enable freezes the folded taps seen by the lookup
	assert property (
		@(posedge sys_clk) disable iff (reset)
		!sampleEn |=> $stable(preSums)
	) else $error("preSums changed without sampleEn");

endmodule
